// ==== src/wfifo_pkg.sv ====
package wfifo_pkg;

    // read side lane geometry
    localparam int LANE_W     = 8;
    localparam int LANES      = 4;
    localparam int WORD_W     = LANES * LANE_W;
    localparam int LANE_IDX_W = 2;

    typedef logic [LANE_W-1:0] lane_t;

    // one stored word, written as a whole and read out lane by lane
    // lanes[LANES-1] holds the most significant byte
    typedef union packed {
        logic [WORD_W-1:0]     raw;
        lane_t [LANES-1:0]     lanes;
    } word_u;

    // output register state of the FWFT read path
    typedef enum logic {
        RD_IDLE    = 1'b0,
        RD_PRESENT = 1'b1
    } rd_state_t;

endpackage

// ==== src/word_ram.sv ====
`timescale 1ns/1ns

module word_ram #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  rd_clock,
    input  logic                  wr_accept,
    input  logic [DEPTH_LOG2-1:0] wr_addr,
    input  wfifo_pkg::word_u      din,
    input  logic                  word_fetch,
    input  logic [DEPTH_LOG2-1:0] rd_addr,
    output wfifo_pkg::word_u      rd_word
);

    import wfifo_pkg::*;

    // simple dual port word array
    logic [WORD_W-1:0] mem [2**DEPTH_LOG2];

    always_ff @(posedge rd_clock) begin
        if (wr_accept) begin
            mem[wr_addr] <= din.raw;
        end
    end

    // registered read port that holds its word between fetches
    always_ff @(posedge rd_clock) begin
        if (word_fetch) begin
            rd_word.raw <= mem[rd_addr];
        end
    end

endmodule

// ==== src/fifo_pointers.sv ====
`timescale 1ns/1ns

module fifo_pointers #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  rd_clock,
    input  logic                  rd_rst,
    input  logic                  wr_en,
    input  logic                  word_fetch,
    output logic                  wr_accept,
    output logic [DEPTH_LOG2-1:0] wr_addr,
    output logic [DEPTH_LOG2-1:0] rd_addr,
    output logic [DEPTH_LOG2:0]   word_count,
    output logic                  full
);

    // occupancy value when every RAM slot holds a word
    localparam logic [DEPTH_LOG2:0] DEPTH_WORDS = {1'b1, {DEPTH_LOG2{1'b0}}};

    assign full      = (word_count == DEPTH_WORDS);
    assign wr_accept = wr_en & ~full;

    // write address wraps naturally at the RAM size
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            wr_addr <= '0;
        end else if (wr_accept) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // a fetch moves one word into the output register
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            rd_addr <= '0;
        end else if (word_fetch) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // words in RAM not yet fetched
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            word_count <= '0;
        end else begin
            case ({wr_accept, word_fetch})
                2'b10: begin
                    word_count <= word_count + 1'b1;
                end
                2'b01: begin
                    word_count <= word_count - 1'b1;
                end
                default: begin
                    // accept and fetch together leave the count alone
                    word_count <= word_count;
                end
            endcase
        end
    end

endmodule

// ==== src/fwft_ctrl.sv ====
`timescale 1ns/1ns

module fwft_ctrl #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                rd_clock,
    input  logic                rd_rst,
    input  logic                rd_en,
    input  logic [DEPTH_LOG2:0] word_count,
    input  logic                last_lane,
    output logic                word_fetch,
    output logic                lane_pop,
    output logic                valid
);

    import wfifo_pkg::*;

    rd_state_t state;
    rd_state_t state_nxt;
    logic      words_stored;

    assign words_stored = (word_count != '0);
    assign valid        = (state == RD_PRESENT);
    assign lane_pop     = rd_en & valid;

    always_comb begin
        state_nxt  = state;
        word_fetch = 1'b0;
        case (state)
            RD_IDLE: begin
                // prefetch as soon as a word sits in the RAM
                if (words_stored) begin
                    word_fetch = 1'b1;
                    state_nxt  = RD_PRESENT;
                end
            end
            RD_PRESENT: begin
                // refill on the last lane so valid has no bubble
                if (lane_pop && last_lane) begin
                    if (words_stored) begin
                        word_fetch = 1'b1;
                    end else begin
                        state_nxt = RD_IDLE;
                    end
                end
            end
            default: begin
                state_nxt = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            state <= RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== src/lane_unpacker.sv ====
`timescale 1ns/1ns

module lane_unpacker (
    input  logic                          rd_clock,
    input  logic                          rd_rst,
    input  logic                          word_fetch,
    input  logic                          lane_pop,
    input  wfifo_pkg::word_u              rd_word,
    output wfifo_pkg::lane_t              dout,
    output logic                          last_lane,
    output logic [wfifo_pkg::LANE_IDX_W:0] lanes_left
);

    import wfifo_pkg::*;

    localparam logic [LANE_IDX_W-1:0] TOP_LANE = LANE_IDX_W'(LANES - 1);

    // index of the lane currently shown on dout
    logic [LANE_IDX_W-1:0] lane_idx;

    // a new word always starts at the most significant lane
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            lane_idx <= TOP_LANE;
        end else if (word_fetch) begin
            lane_idx <= TOP_LANE;
        end else if (lane_pop) begin
            // wraps back to the top lane after lane 0
            lane_idx <= lane_idx - 1'b1;
        end
    end

    assign dout       = rd_word.lanes[lane_idx];
    assign last_lane  = (lane_idx == '0);
    assign lanes_left = {1'b0, lane_idx} + 1'b1;

endmodule

// ==== src/flag_gen.sv ====
`timescale 1ns/1ns

module flag_gen #(
    parameter int DEPTH_LOG2        = 4,
    parameter int PROG_FULL_THRESH  = 12,
    parameter int PROG_EMPTY_THRESH = 6
) (
    input  logic                           rd_clock,
    input  logic                           rd_rst,
    input  logic                           wr_en,
    input  logic                           rd_en,
    input  logic                           full,
    input  logic                           valid,
    input  logic [DEPTH_LOG2:0]            word_count,
    input  logic [wfifo_pkg::LANE_IDX_W:0] lanes_left,
    output logic [DEPTH_LOG2+2:0]          rd_data_count,
    output logic                           prog_full,
    output logic                           prog_empty,
    output logic                           overflow,
    output logic                           underflow
);

    import wfifo_pkg::*;

    localparam int CNT_W = DEPTH_LOG2 + 3;

    logic [CNT_W-1:0] stored_lanes;
    logic [CNT_W-1:0] shown_lanes;

    // lanes still in RAM plus what is left of the presented word
    assign stored_lanes  = CNT_W'(word_count) * CNT_W'(LANES);
    assign shown_lanes   = valid ? CNT_W'(lanes_left) : '0;
    assign rd_data_count = stored_lanes + shown_lanes;

    // prog_full counts words, prog_empty counts lanes
    assign prog_full  = (word_count >= PROG_FULL_THRESH);
    assign prog_empty = (rd_data_count <= PROG_EMPTY_THRESH);

    // refused requests, flagged in the cycle after the edge
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= wr_en & full;
            underflow <= rd_en & ~valid;
        end
    end

endmodule

// ==== src/narrowing_fifo.sv ====
`timescale 1ns/1ns

module narrowing_fifo #(
    parameter int DEPTH_LOG2        = 4,
    parameter int PROG_FULL_THRESH  = 12,
    parameter int PROG_EMPTY_THRESH = 6
) (
    input  logic                  rd_clock,
    input  logic                  rd_rst,
    input  logic                  wr_en,
    input  wfifo_pkg::word_u      din,
    input  logic                  rd_en,
    output logic                  wr_ready,
    output logic                  full,
    output logic                  valid,
    output wfifo_pkg::lane_t      dout,
    output logic [DEPTH_LOG2:0]   wr_data_count,
    output logic [DEPTH_LOG2+2:0] rd_data_count,
    output logic                  prog_full,
    output logic                  prog_empty,
    output logic                  overflow,
    output logic                  underflow
);

    import wfifo_pkg::*;

    logic                  wr_accept;
    logic [DEPTH_LOG2-1:0] wr_addr;
    logic [DEPTH_LOG2-1:0] rd_addr;
    logic [DEPTH_LOG2:0]   word_count;
    logic                  word_fetch;
    logic                  lane_pop;
    logic                  last_lane;
    logic [LANE_IDX_W:0]   lanes_left;
    word_u                 rd_word;

    assign wr_ready      = ~full;
    assign wr_data_count = word_count;

    fifo_pointers #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_fifo_pointers (
        .rd_clock   (rd_clock),
        .rd_rst     (rd_rst),
        .wr_en      (wr_en),
        .word_fetch (word_fetch),
        .wr_accept  (wr_accept),
        .wr_addr    (wr_addr),
        .rd_addr    (rd_addr),
        .word_count (word_count),
        .full       (full)
    );

    word_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_word_ram (
        .rd_clock   (rd_clock),
        .wr_accept  (wr_accept),
        .wr_addr    (wr_addr),
        .din        (din),
        .word_fetch (word_fetch),
        .rd_addr    (rd_addr),
        .rd_word    (rd_word)
    );

    fwft_ctrl #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_fwft_ctrl (
        .rd_clock   (rd_clock),
        .rd_rst     (rd_rst),
        .rd_en      (rd_en),
        .word_count (word_count),
        .last_lane  (last_lane),
        .word_fetch (word_fetch),
        .lane_pop   (lane_pop),
        .valid      (valid)
    );

    lane_unpacker u_lane_unpacker (
        .rd_clock   (rd_clock),
        .rd_rst     (rd_rst),
        .word_fetch (word_fetch),
        .lane_pop   (lane_pop),
        .rd_word    (rd_word),
        .dout       (dout),
        .last_lane  (last_lane),
        .lanes_left (lanes_left)
    );

    flag_gen #(
        .DEPTH_LOG2        (DEPTH_LOG2),
        .PROG_FULL_THRESH  (PROG_FULL_THRESH),
        .PROG_EMPTY_THRESH (PROG_EMPTY_THRESH)
    ) u_flag_gen (
        .rd_clock      (rd_clock),
        .rd_rst        (rd_rst),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .full          (full),
        .valid         (valid),
        .word_count    (word_count),
        .lanes_left    (lanes_left),
        .rd_data_count (rd_data_count),
        .prog_full     (prog_full),
        .prog_empty    (prog_empty),
        .overflow      (overflow),
        .underflow     (underflow)
    );

endmodule

// ==== bench/tb_checks.svh ====
// lane k of a stored word, k = 0 is the most significant lane
function automatic lane_t expect_lane(input word_u w, input int k);
    int shift;
    shift = WORD_W - LANE_W * (k + 1);
    return lane_t'(w.raw >> shift);
endfunction

// report the reason, then end the run
task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_lane(input string name, input lane_t exp, input lane_t act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %02h, actual %02h", name, exp, act));
    end
endtask

task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        abort_run($sformatf("ERR %s: expected %0b, actual %0b", name, exp, act));
    end
endtask

// ==== bench/tb_narrowing_fifo.sv ====
`timescale 1ns/1ns

module tb_narrowing_fifo;

    import wfifo_pkg::*;

    localparam int DEPTH_LOG2        = 4;
    localparam int PROG_FULL_THRESH  = 12;
    localparam int PROG_EMPTY_THRESH = 6;
    localparam int CNT_W             = DEPTH_LOG2 + 3;
    localparam int STREAM_WORDS      = 300;
    // one fwft word, the fill plus one refused write, then streaming
    localparam int TOTAL_WRITES      = 1 + (2**DEPTH_LOG2 + 2) + STREAM_WORDS;
    localparam int TIMEOUT_CYCLES    = TOTAL_WRITES * LANES * 4 + 200;

    logic                rd_clock = 1'b0;
    logic                rd_rst;
    logic                wr_en;
    word_u               din;
    logic                rd_en;
    logic                wr_ready;
    logic                full;
    logic                valid;
    lane_t               dout;
    logic [DEPTH_LOG2:0] wr_data_count;
    logic [CNT_W-1:0]    rd_data_count;
    logic                prog_full;
    logic                prog_empty;
    logic                overflow;
    logic                underflow;

    // model of the FIFO contents with the word on dout at the front
    word_u       model_q[$];
    int          lane_k = 0;
    int unsigned lanes_consumed = 0;
    string       test_name = "reset";

    `include "tb_checks.svh"

    narrowing_fifo #(
        .DEPTH_LOG2        (DEPTH_LOG2),
        .PROG_FULL_THRESH  (PROG_FULL_THRESH),
        .PROG_EMPTY_THRESH (PROG_EMPTY_THRESH)
    ) u_narrowing_fifo (
        .rd_clock      (rd_clock),
        .rd_rst        (rd_rst),
        .wr_en         (wr_en),
        .din           (din),
        .rd_en         (rd_en),
        .wr_ready      (wr_ready),
        .full          (full),
        .valid         (valid),
        .dout          (dout),
        .wr_data_count (wr_data_count),
        .rd_data_count (rd_data_count),
        .prog_full     (prog_full),
        .prog_empty    (prog_empty),
        .overflow      (overflow),
        .underflow     (underflow)
    );

    initial begin
        forever #50 rd_clock = ~rd_clock;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge rd_clock);
        abort_run("watchdog expired before all tests finished");
    end

    // compare consumed lanes and track accepted writes at each rising edge
    always @(posedge rd_clock) begin
        if (rd_rst) begin
            if (rd_en && valid) begin
                if (model_q.size() == 0) begin
                    abort_run("DUT delivered a lane while the model holds no word");
                end else begin
                    check_lane(test_name, expect_lane(model_q[0], lane_k), dout);
                    lanes_consumed = lanes_consumed + 1;
                    if (lane_k == LANES - 1) begin
                        lane_k = 0;
                        void'(model_q.pop_front());
                    end else begin
                        lane_k = lane_k + 1;
                    end
                end
            end
            if (wr_en && wr_ready) begin
                model_q.push_back(din);
            end
        end
    end

    // counts and thresholds of a FIFO with no fetch pending
    task automatic check_idle_counts(input string step);
        int unsigned words;
        int unsigned exp_wr;
        int unsigned exp_rd;
        words  = model_q.size();
        exp_wr = (words > 0) ? words - 1 : 0;
        exp_rd = words * LANES - lane_k;
        check_count({step, " wr_data_count"}, CNT_W'(exp_wr), CNT_W'(wr_data_count));
        check_count({step, " rd_data_count"}, CNT_W'(exp_rd), rd_data_count);
        check_flag({step, " prog_full"}, exp_wr >= PROG_FULL_THRESH, prog_full);
        check_flag({step, " prog_empty"}, exp_rd <= PROG_EMPTY_THRESH, prog_empty);
    endtask

    initial begin
        word_u       first_word;
        int unsigned accepted;
        int unsigned lanes;
        int unsigned sent;
        int unsigned target;
        int unsigned seed;

        seed    = $urandom(32'hee42);
        rd_rst  = 1'b0;
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        din.raw = '0;
        repeat (2) @(negedge rd_clock);
        rd_rst = 1'b1;

        @(negedge rd_clock);
        check_flag("reset valid", 1'b0, valid);
        check_flag("reset full", 1'b0, full);
        check_flag("reset overflow", 1'b0, overflow);
        check_flag("reset underflow", 1'b0, underflow);
        check_flag("reset wr_ready", 1'b1, wr_ready);
        check_idle_counts("reset");

        // one word is shown before any read request
        test_name      = "fwft order";
        first_word.raw = $urandom;
        din            = first_word;
        wr_en          = 1'b1;
        @(negedge rd_clock);
        wr_en = 1'b0;
        check_flag("fwft valid before fetch", 1'b0, valid);
        @(negedge rd_clock);
        check_flag("fwft valid after fetch", 1'b1, valid);
        check_lane("fwft top lane", expect_lane(first_word, 0), dout);
        rd_en = 1'b1;
        repeat (LANES) @(negedge rd_clock);
        rd_en = 1'b0;
        check_flag("fwft valid after last lane", 1'b0, valid);
        check_count("fwft words left", '0, CNT_W'(model_q.size()));

        // fill with no reads while the output register takes one extra word
        test_name = "fill";
        accepted  = 0;
        while (wr_ready && accepted < 2 * 2**DEPTH_LOG2) begin
            din.raw = $urandom;
            wr_en   = 1'b1;
            @(negedge rd_clock);
            wr_en    = 1'b0;
            accepted = accepted + 1;
            @(negedge rd_clock);
            check_idle_counts("fill step");
        end
        check_count("writes accepted until full", CNT_W'(2**DEPTH_LOG2 + 1), CNT_W'(accepted));
        check_flag("full after fill", 1'b1, full);

        din.raw = 32'hdead_beef;
        wr_en   = 1'b1;
        @(negedge rd_clock);
        wr_en = 1'b0;
        check_flag("overflow raised", 1'b1, overflow);
        @(negedge rd_clock);
        check_flag("overflow cleared", 1'b0, overflow);
        check_idle_counts("after overflow");

        // partial pops leave the front word half read
        test_name = "drain";
        while (model_q.size() > 0) begin
            lanes = $urandom_range(1, LANES);
            rd_en = 1'b1;
            repeat (lanes) @(negedge rd_clock);
            rd_en = 1'b0;
            @(negedge rd_clock);
            check_idle_counts("drain step");
        end

        test_name = "random streaming";
        target    = lanes_consumed + STREAM_WORDS * LANES;
        sent      = 0;
        fork
            begin
                while (sent < STREAM_WORDS) begin
                    wr_en   = ($urandom_range(0, 1) == 1);
                    din.raw = $urandom;
                    if (wr_en && wr_ready) begin
                        sent = sent + 1;
                    end
                    @(negedge rd_clock);
                end
                wr_en = 1'b0;
            end
            begin
                while (lanes_consumed < target) begin
                    rd_en = ($urandom_range(0, 1) == 1);
                    @(negedge rd_clock);
                end
                rd_en = 1'b0;
            end
        join
        @(negedge rd_clock);
        check_flag("stream valid after last lane", 1'b0, valid);
        check_idle_counts("after streaming");

        test_name = "underflow";
        check_flag("underflow idle", 1'b0, underflow);
        rd_en = 1'b1;
        @(negedge rd_clock);
        rd_en = 1'b0;
        check_flag("underflow raised", 1'b1, underflow);
        check_flag("underflow valid", 1'b0, valid);
        check_idle_counts("after underflow");
        @(negedge rd_clock);
        check_flag("underflow cleared", 1'b0, underflow);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== narrowing_fifo.f ====
+incdir+bench
src/wfifo_pkg.sv
src/word_ram.sv
src/fifo_pointers.sv
src/fwft_ctrl.sv
src/lane_unpacker.sv
src/flag_gen.sv
src/narrowing_fifo.sv
bench/tb_narrowing_fifo.sv

// ==== Makefile ====
# Verilator build and run for the narrowing FIFO testbench

SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = tb_narrowing_fifo
FILELIST = narrowing_fifo.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test OK

SOURCES  = $(wildcard src/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
